/* list.f */
+incdir+source
+incdir+test
source/alu_pkg.sv
source/execute_if.sv
source/commit_if.sv
source/int_unit.sv
source/muldiv_unit.sv
source/rsp_arb.sv
source/alu_unit.sv
test/alu_unit_tb.sv

/* source/alu_macros.svh */
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// Width of one operand or result on the scalar lane
`define XLEN_W 32

// Instruction tag, matched by the consumer on commit
`define TAG_W 8

// Warp id, four warps share the lane
`define WID_W 2

// Destination register index
`define NR_W 5

// Register stages in the multiplier pipeline
`define MUL_LAT 3

`endif

/* source/alu_pkg.sv */
`include "alu_macros.svh"

package alu_pkg;

    typedef logic [`XLEN_W-1:0] word_t;
    typedef logic [`TAG_W-1:0]  tag_t;
    typedef logic [`WID_W-1:0]  wid_t;
    typedef logic [`NR_W-1:0]   reg_idx_t;

    // Plain integer ops first, then branches and JAL, then the M extension
    typedef enum logic [4:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        JAL,
        MUL,
        MULH,
        MULHU,
        DIV,
        DIVU,
        REM,
        REMU
    } alu_op_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } div_state_t;

endpackage

/* source/alu_unit.sv */
`timescale 1ns/1ps

module alu_unit import alu_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,

    input  logic     disp_valid,
    output logic     disp_ready,
    input  tag_t     disp_tag,
    input  wid_t     disp_wid,
    input  reg_idx_t disp_rd,
    input  alu_op_t  disp_op,
    input  word_t    disp_rs1,
    input  word_t    disp_rs2,
    input  word_t    disp_imm,
    input  word_t    disp_pc,

    output logic     cmt_valid,
    input  logic     cmt_ready,
    output tag_t     cmt_tag,
    output wid_t     cmt_wid,
    output reg_idx_t cmt_rd,
    output word_t    cmt_data,

    output logic     br_valid,
    output wid_t     br_wid,
    output logic     br_taken,
    output word_t    br_target
);

    localparam int INT_IDX = 0;
    localparam int MDV_IDX = 1;

    logic is_muldiv;

    execute_if exe_if [2] ();
    commit_if  cmt_if [2] ();

    assign is_muldiv = disp_op inside {MUL, MULH, MULHU, DIV, DIVU, REM, REMU};

    // Both units see the payload, only the chosen one sees valid
    for (genvar i = 0; i < 2; i++) begin : g_steer
        assign exe_if[i].valid = disp_valid & (is_muldiv == (i == MDV_IDX));
        assign exe_if[i].tag   = disp_tag;
        assign exe_if[i].wid   = disp_wid;
        assign exe_if[i].rd    = disp_rd;
        assign exe_if[i].op    = disp_op;
        assign exe_if[i].rs1   = disp_rs1;
        assign exe_if[i].rs2   = disp_rs2;
        assign exe_if[i].imm   = disp_imm;
        assign exe_if[i].pc    = disp_pc;
    end

    assign disp_ready = is_muldiv ? exe_if[MDV_IDX].ready : exe_if[INT_IDX].ready;

    int_unit int_unit0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .exe       (exe_if[INT_IDX]),
        .cmt       (cmt_if[INT_IDX]),
        .br_valid  (br_valid),
        .br_wid    (br_wid),
        .br_taken  (br_taken),
        .br_target (br_target)
    );

    muldiv_unit mdv_unit0 (
        .clk    (clk),
        .arst_n (arst_n),
        .exe    (exe_if[MDV_IDX]),
        .cmt    (cmt_if[MDV_IDX])
    );

    rsp_arb rsp_arb0 (
        .clk    (clk),
        .arst_n (arst_n),
        .int_in (cmt_if[INT_IDX]),
        .mdv_in (cmt_if[MDV_IDX]),
        .valid  (cmt_valid),
        .ready  (cmt_ready),
        .tag    (cmt_tag),
        .wid    (cmt_wid),
        .rd     (cmt_rd),
        .data   (cmt_data)
    );

endmodule

/* source/commit_if.sv */
`timescale 1ns/1ps

// Result of one unit, waiting for the response arbiter
interface commit_if import alu_pkg::*; ();

    logic     valid;
    logic     ready;
    tag_t     tag;
    wid_t     wid;
    reg_idx_t rd;
    word_t    data;

    modport master (
        output valid, tag, wid, rd, data,
        input  ready
    );

    modport slave (
        input  valid, tag, wid, rd, data,
        output ready
    );

endinterface

/* source/execute_if.sv */
`timescale 1ns/1ps

// One dispatched instruction on its way into a functional unit
interface execute_if import alu_pkg::*; ();

    logic     valid;
    logic     ready;
    tag_t     tag;
    wid_t     wid;
    reg_idx_t rd;
    alu_op_t  op;
    word_t    rs1;
    word_t    rs2;
    word_t    imm;
    word_t    pc;

    modport master (
        output valid, tag, wid, rd, op, rs1, rs2, imm, pc,
        input  ready
    );

    modport slave (
        input  valid, tag, wid, rd, op, rs1, rs2, imm, pc,
        output ready
    );

endinterface

/* source/int_unit.sv */
`timescale 1ns/1ps

module int_unit import alu_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    execute_if.slave exe,
    commit_if.master cmt,
    output logic     br_valid,
    output wid_t     br_wid,
    output logic     br_taken,
    output word_t    br_target
);

    localparam int SHAMT_W = $clog2($bits(word_t));

    logic               fire;
    logic               is_branch;
    logic               taken;
    logic [SHAMT_W-1:0] shamt;
    word_t              alu_res;

    logic     out_valid;
    tag_t     out_tag;
    wid_t     out_wid;
    reg_idx_t out_rd;
    word_t    out_data;

    assign shamt = exe.rs2[SHAMT_W-1:0];

    // Branches commit a zero result, JAL commits its link address
    always_comb begin
        alu_res = '0;
        case (exe.op)
            ADD:  alu_res = exe.rs1 + exe.rs2;
            SUB:  alu_res = exe.rs1 - exe.rs2;
            AND:  alu_res = exe.rs1 & exe.rs2;
            OR:   alu_res = exe.rs1 | exe.rs2;
            XOR:  alu_res = exe.rs1 ^ exe.rs2;
            SLL:  alu_res = exe.rs1 << shamt;
            SRL:  alu_res = exe.rs1 >> shamt;
            SRA:  alu_res = word_t'($signed(exe.rs1) >>> shamt);
            SLT:  alu_res = word_t'($signed(exe.rs1) < $signed(exe.rs2));
            SLTU: alu_res = word_t'(exe.rs1 < exe.rs2);
            JAL:  alu_res = exe.pc + word_t'(4);
            default: alu_res = '0;
        endcase
    end

    always_comb begin
        is_branch = 1'b1;
        taken     = 1'b0;
        case (exe.op)
            BEQ:  taken = (exe.rs1 == exe.rs2);
            BNE:  taken = (exe.rs1 != exe.rs2);
            BLT:  taken = ($signed(exe.rs1) < $signed(exe.rs2));
            BGE:  taken = ($signed(exe.rs1) >= $signed(exe.rs2));
            BLTU: taken = (exe.rs1 < exe.rs2);
            BGEU: taken = (exe.rs1 >= exe.rs2);
            JAL:  taken = 1'b1;
            default: is_branch = 1'b0;
        endcase
    end

    // The register accepts a new item when empty or when its content leaves
    assign exe.ready = ~out_valid | cmt.ready;
    assign fire      = exe.valid & exe.ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            br_valid  <= 1'b0;
        end else begin
            if (exe.ready) begin
                out_valid <= exe.valid;
            end
            // The pulse follows the load and ignores commit back-pressure
            br_valid <= fire & is_branch;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            out_tag  <= exe.tag;
            out_wid  <= exe.wid;
            out_rd   <= exe.rd;
            out_data <= alu_res;
        end
        if (fire && is_branch) begin
            br_wid    <= exe.wid;
            br_taken  <= taken;
            br_target <= exe.pc + exe.imm;
        end
    end

    assign cmt.valid = out_valid;
    assign cmt.tag   = out_tag;
    assign cmt.wid   = out_wid;
    assign cmt.rd    = out_rd;
    assign cmt.data  = out_data;

endmodule

/* source/muldiv_unit.sv */
`timescale 1ns/1ps
`include "alu_macros.svh"

module muldiv_unit import alu_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    execute_if.slave exe,
    commit_if.master cmt
);

    localparam int CNT_W = $clog2(`XLEN_W);

    logic  fire;
    logic  is_div;
    logic  is_sdiv;
    logic  mul_adv;
    logic  div_out;
    word_t abs_a;
    word_t abs_b;

    logic [`MUL_LAT-1:0]         m_vld;
    tag_t                        m_tag [`MUL_LAT];
    wid_t                        m_wid [`MUL_LAT];
    reg_idx_t                    m_rd  [`MUL_LAT];
    logic signed [`XLEN_W:0]     m1_a;
    logic signed [`XLEN_W:0]     m1_b;
    logic                        m1_hi;
    logic signed [2*`XLEN_W+1:0] m2_prod;
    logic                        m2_hi;
    word_t                       m3_res;

    div_state_t       div_state;
    logic [CNT_W-1:0] div_cnt;
    word_t            div_rem;
    word_t            div_quo;
    word_t            div_dvs;
    word_t            div_dvd;
    logic             div_neg_q;
    logic             div_neg_r;
    logic             div_by_zero;
    logic             div_ovf;
    logic             div_is_rem;
    tag_t             div_tag;
    wid_t             div_wid;
    reg_idx_t         div_rd;
    logic [`XLEN_W:0] rem_sh;
    logic [`XLEN_W:0] diff;
    word_t            q_fix;
    word_t            r_fix;
    word_t            div_res;

    assign is_div  = exe.op inside {DIV, DIVU, REM, REMU};
    assign is_sdiv = exe.op inside {DIV, REM};
    assign abs_a   = (is_sdiv && exe.rs1[`XLEN_W-1]) ? -exe.rs1 : exe.rs1;
    assign abs_b   = (is_sdiv && exe.rs2[`XLEN_W-1]) ? -exe.rs2 : exe.rs2;

    // A finished divide owns the output, so the multiplier waits behind it
    assign div_out   = (div_state == DONE);
    assign mul_adv   = ~m_vld[`MUL_LAT-1] | (cmt.ready & ~div_out);
    assign exe.ready = (div_state == IDLE) & mul_adv;
    assign fire      = exe.valid & exe.ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m_vld     <= '0;
            div_state <= IDLE;
            div_cnt   <= '0;
        end else begin
            if (mul_adv) begin
                m_vld <= {m_vld[`MUL_LAT-2:0], fire & ~is_div};
            end
            case (div_state)
                IDLE: begin
                    if (fire && is_div) begin
                        div_state <= RUN;
                        div_cnt   <= '0;
                    end
                end
                RUN: begin
                    div_cnt <= div_cnt + 1'b1;
                    if (div_cnt == CNT_W'(`XLEN_W-1)) begin
                        div_state <= DONE;
                    end
                end
                DONE: begin
                    if (cmt.ready) begin
                        div_state <= IDLE;
                    end
                end
                default: div_state <= IDLE;
            endcase
        end
    end

    // Operands are widened by one bit so that one signed multiply covers all three ops
    always_ff @(posedge clk) begin
        if (mul_adv) begin
            m_tag[0] <= exe.tag;
            m_wid[0] <= exe.wid;
            m_rd[0]  <= exe.rd;
            for (int i = 1; i < `MUL_LAT; i++) begin
                m_tag[i] <= m_tag[i-1];
                m_wid[i] <= m_wid[i-1];
                m_rd[i]  <= m_rd[i-1];
            end
            m1_a    <= {(exe.op != MULHU) & exe.rs1[`XLEN_W-1], exe.rs1};
            m1_b    <= {(exe.op != MULHU) & exe.rs2[`XLEN_W-1], exe.rs2};
            m1_hi   <= (exe.op != MUL);
            m2_prod <= m1_a * m1_b;
            m2_hi   <= m1_hi;
            m3_res  <= m2_hi ? m2_prod[2*`XLEN_W-1:`XLEN_W] : m2_prod[`XLEN_W-1:0];
        end
    end

    // One restoring step per cycle on the magnitudes
    assign rem_sh = {div_rem, div_quo[`XLEN_W-1]};
    assign diff   = rem_sh - {1'b0, div_dvs};

    always_ff @(posedge clk) begin
        if (fire && is_div) begin
            div_rem     <= '0;
            div_quo     <= abs_a;
            div_dvs     <= abs_b;
            div_dvd     <= exe.rs1;
            div_neg_q   <= is_sdiv & (exe.rs1[`XLEN_W-1] ^ exe.rs2[`XLEN_W-1]);
            div_neg_r   <= is_sdiv & exe.rs1[`XLEN_W-1];
            div_by_zero <= (exe.rs2 == '0);
            div_ovf     <= is_sdiv & (exe.rs1 == {1'b1, {(`XLEN_W-1){1'b0}}}) & (exe.rs2 == '1);
            div_is_rem  <= exe.op inside {REM, REMU};
            div_tag     <= exe.tag;
            div_wid     <= exe.wid;
            div_rd      <= exe.rd;
        end else if (div_state == RUN) begin
            div_quo <= {div_quo[`XLEN_W-2:0], ~diff[`XLEN_W]};
            div_rem <= diff[`XLEN_W] ? rem_sh[`XLEN_W-1:0] : diff[`XLEN_W-1:0];
        end
    end

    assign q_fix = div_neg_q ? -div_quo : div_quo;
    assign r_fix = div_neg_r ? -div_rem : div_rem;

    always_comb begin
        if (div_by_zero) begin
            div_res = div_is_rem ? div_dvd : '1;
        end else if (div_ovf) begin
            div_res = div_is_rem ? '0 : div_dvd;
        end else begin
            div_res = div_is_rem ? r_fix : q_fix;
        end
    end

    assign cmt.valid = div_out | m_vld[`MUL_LAT-1];
    assign cmt.tag   = div_out ? div_tag : m_tag[`MUL_LAT-1];
    assign cmt.wid   = div_out ? div_wid : m_wid[`MUL_LAT-1];
    assign cmt.rd    = div_out ? div_rd : m_rd[`MUL_LAT-1];
    assign cmt.data  = div_out ? div_res : m3_res;

endmodule

/* source/rsp_arb.sv */
`timescale 1ns/1ps

module rsp_arb import alu_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    commit_if.slave  int_in,
    commit_if.slave  mdv_in,
    output logic     valid,
    input  logic     ready,
    output tag_t     tag,
    output wid_t     wid,
    output reg_idx_t rd,
    output word_t    data
);

    logic load_ok;
    logic grant_int;
    logic grant_mdv;
    logic rr_mdv;

    // rr_mdv set means the muldiv side wins the next tie
    assign load_ok   = ~valid | ready;
    assign grant_int = int_in.valid & (~mdv_in.valid | ~rr_mdv);
    assign grant_mdv = mdv_in.valid & ~grant_int;

    assign int_in.ready = load_ok & grant_int;
    assign mdv_in.ready = load_ok & grant_mdv;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid  <= 1'b0;
            rr_mdv <= 1'b0;
        end else if (load_ok) begin
            valid <= grant_int | grant_mdv;
            if (grant_int || grant_mdv) begin
                rr_mdv <= grant_int;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_ok && grant_mdv) begin
            tag  <= mdv_in.tag;
            wid  <= mdv_in.wid;
            rd   <= mdv_in.rd;
            data <= mdv_in.data;
        end else if (load_ok && grant_int) begin
            tag  <= int_in.tag;
            wid  <= int_in.wid;
            rd   <= int_in.rd;
            data <= int_in.data;
        end
    end

endmodule

/* test/alu_model.svh */
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// Result that should commit for one instruction, following the RISC-V rules
function automatic word_t model_result(alu_op_t op, word_t a, word_t b, word_t pc);
    logic signed [63:0] sprod;
    logic [63:0]        uprod;
    logic               ovf;
    logic signed [31:0] sq;
    logic signed [31:0] sr;
    sprod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
    uprod = {32'b0, a} * {32'b0, b};
    ovf   = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    case (op)
        ADD:   return a + b;
        SUB:   return a - b;
        AND:   return a & b;
        OR:    return a | b;
        XOR:   return a ^ b;
        SLL:   return a << b[4:0];
        SRL:   return a >> b[4:0];
        SRA:   return $signed(a) >>> b[4:0];
        SLT:   return word_t'($signed(a) < $signed(b));
        SLTU:  return word_t'(a < b);
        JAL:   return pc + 32'd4;
        MUL:   return sprod[31:0];
        MULH:  return sprod[63:32];
        MULHU: return uprod[63:32];
        DIV, REM: begin
            if (b == '0) return (op == DIV) ? '1 : a;
            if (ovf) return (op == DIV) ? a : '0;
            sq = $signed(a) / $signed(b);
            sr = $signed(a) % $signed(b);
            return (op == DIV) ? sq : sr;
        end
        DIVU, REMU: begin
            if (b == '0) return (op == DIVU) ? '1 : a;
            return (op == DIVU) ? a / b : a % b;
        end
        // Conditional branches commit nothing useful
        default: return '0;
    endcase
endfunction

function automatic logic model_taken(alu_op_t op, word_t a, word_t b);
    case (op)
        BEQ:  return a == b;
        BNE:  return a != b;
        BLT:  return $signed(a) < $signed(b);
        BGE:  return $signed(a) >= $signed(b);
        BLTU: return a < b;
        BGEU: return a >= b;
        JAL:  return 1'b1;
        default: return 1'b0;
    endcase
endfunction

`endif

/* test/alu_unit_tb.sv */
`timescale 1ns/1ps

module alu_unit_tb import alu_pkg::*; ();

    `include "alu_model.svh"

    localparam int RST_CYCLES = 16;
    localparam int REPS       = 4;
    localparam int MIX_OPS    = 32;
    // About 180 ops; even if every mixed op were a 36-cycle divide the run stays near 3200
    localparam int MAX_CYCLES = 4000;

    logic     clk, arst_n, disp_valid, disp_ready, cmt_valid, cmt_ready, br_valid, br_taken;
    tag_t     disp_tag, cmt_tag;
    wid_t     disp_wid, cmt_wid, br_wid;
    reg_idx_t disp_rd, cmt_rd;
    alu_op_t  disp_op;
    word_t    disp_rs1, disp_rs2, disp_imm, disp_pc, cmt_data, br_target;

    typedef struct packed {
        wid_t  wid;
        logic  taken;
        word_t target;
    } br_exp_t;

    logic [15:0] op_lfsr, rdy_lfsr;
    int          cycle, errors, err_mark, n_pend, n_commits, n_branches, test_idx;
    logic        disp_xfer, stall_en, check_lat;
    tag_t        next_tag;
    logic        exp_pend [256];
    word_t       exp_data [256];
    wid_t        exp_wid  [256];
    reg_idx_t    exp_rd   [256];
    int          disp_cyc [256];
    br_exp_t     br_q [$];
    br_exp_t     br_head;

    alu_unit dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Taps for x^16 + x^14 + x^13 + x^11 + 1, the new bit enters at bit 0
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic word_t rand_bits(int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            op_lfsr = lfsr_next(op_lfsr);
            v = {v[30:0], op_lfsr[0]};
        end
        return v;
    endfunction

    task automatic report_mismatch(string name, word_t exp, word_t act);
        $display("[ERROR] %s: expected %h, got %h", name, exp, act);
        errors++;
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles with %0d results outstanding", cycle, n_pend);
            $display("Simulation failed");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (stall_en) begin
            rdy_lfsr  = lfsr_next(rdy_lfsr);
            cmt_ready = rdy_lfsr[0];
        end else begin
            cmt_ready = 1'b1;
        end
    end

    always @(posedge clk) begin
        disp_xfer <= disp_valid & disp_ready;
        if (disp_valid && disp_ready) begin
            disp_cyc[disp_tag] <= cycle;
        end
    end

    // Scoreboard lookup by tag for every commit transfer
    always @(posedge clk) begin
        if (arst_n && cmt_valid && cmt_ready) begin
            assert (exp_pend[cmt_tag]) else begin
                $display("Commit with tag %h that was not outstanding", cmt_tag);
                errors++;
            end
            if (exp_pend[cmt_tag]) begin
                assert (cmt_data == exp_data[cmt_tag])
                    else report_mismatch("cmt_data", exp_data[cmt_tag], cmt_data);
                assert (cmt_wid == exp_wid[cmt_tag])
                    else report_mismatch("cmt_wid", word_t'(exp_wid[cmt_tag]), word_t'(cmt_wid));
                assert (cmt_rd == exp_rd[cmt_tag])
                    else report_mismatch("cmt_rd", word_t'(exp_rd[cmt_tag]), word_t'(cmt_rd));
                assert (!check_lat || cycle - disp_cyc[cmt_tag] == 2) else begin
                    $display("Tag %h committed %0d cycles after dispatch instead of 2",
                             cmt_tag, cycle - disp_cyc[cmt_tag]);
                    errors++;
                end
                exp_pend[cmt_tag] = 1'b0;
                n_pend--;
                n_commits++;
            end
        end
    end

    always @(posedge clk) begin
        if (arst_n && br_valid) begin
            assert (br_q.size() != 0) else begin
                $display("Branch pulse while no branch was outstanding");
                errors++;
            end
            if (br_q.size() != 0) begin
                br_head = br_q.pop_front();
                assert (br_taken == br_head.taken)
                    else report_mismatch("br_taken", word_t'(br_head.taken), word_t'(br_taken));
                assert (br_target == br_head.target)
                    else report_mismatch("br_target", br_head.target, br_target);
                assert (br_wid == br_head.wid)
                    else report_mismatch("br_wid", word_t'(br_head.wid), word_t'(br_wid));
                n_branches++;
            end
        end
    end

    // A stalled commit holds valid and payload until it is taken
    assert property (@(posedge clk) disable iff (!arst_n)
        cmt_valid && !cmt_ready |=> cmt_valid && $stable({cmt_tag, cmt_wid, cmt_rd, cmt_data}))
        else begin
            $display("cmt_valid or its payload changed while the commit was stalled");
            errors++;
        end

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic dispatch(alu_op_t op, word_t rs1, word_t rs2, word_t imm, word_t pc);
        tag_t tag;
        tag = next_tag;
        next_tag++;
        exp_pend[tag] = 1'b1;
        exp_data[tag] = model_result(op, rs1, rs2, pc);
        exp_wid[tag]  = wid_t'(rand_bits(2));
        exp_rd[tag]   = reg_idx_t'(rand_bits(5));
        n_pend++;
        if (op inside {BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL}) begin
            br_q.push_back('{exp_wid[tag], model_taken(op, rs1, rs2), pc + imm});
        end
        disp_valid = 1'b1;
        disp_tag   = tag;
        disp_wid   = exp_wid[tag];
        disp_rd    = exp_rd[tag];
        disp_op    = op;
        disp_rs1   = rs1;
        disp_rs2   = rs2;
        disp_imm   = imm;
        disp_pc    = pc;
        do begin
            @(negedge clk);
        end while (!disp_xfer);
    endtask

    task automatic dispatch_rand(alu_op_t op);
        word_t a;
        word_t b;
        a = rand_bits(32);
        b = rand_bits(32);
        // Equal operands now and then so that BEQ and BGE see their edge
        if (rand_bits(2) == 0) begin
            b = a;
        end
        dispatch(op, a, b, rand_bits(13) - 32'd4096, rand_bits(30) << 2);
    endtask

    task automatic finish_test(string name);
        disp_valid = 1'b0;
        while (n_pend != 0 || br_q.size() != 0) begin
            @(negedge clk);
        end
        test_idx++;
        $display("Test %0d (%s) done with %0d errors", test_idx, name, errors - err_mark);
        err_mark = errors;
    endtask

    initial begin
        arst_n     = 1'b0;
        disp_valid = 1'b0;
        disp_tag   = '0;
        disp_wid   = '0;
        disp_rd    = '0;
        disp_op    = ADD;
        disp_rs1   = '0;
        disp_rs2   = '0;
        disp_imm   = '0;
        disp_pc    = '0;
        cmt_ready  = 1'b1;
        stall_en   = 1'b0;
        check_lat  = 1'b0;
        op_lfsr    = 16'd8;
        rdy_lfsr   = 16'd8;
        cycle      = 0;
        errors     = 0;
        err_mark   = 0;
        n_pend     = 0;
        n_commits  = 0;
        n_branches = 0;
        test_idx   = 0;
        next_tag   = '0;
        for (int i = 0; i < 256; i++) begin
            exp_pend[i] = 1'b0;
        end
        repeat (RST_CYCLES) @(negedge clk);
        arst_n = 1'b1;
        assert (!cmt_valid && !br_valid && disp_ready) else begin
            $display("Outputs are not at their reset values after reset");
            errors++;
        end

        for (int r = 0; r < REPS; r++) begin
            for (int i = int'(ADD); i <= int'(SLTU); i++) dispatch_rand(alu_op_t'(i));
        end
        finish_test("integer ops");

        for (int r = 0; r < REPS; r++) begin
            for (int i = int'(BEQ); i <= int'(JAL); i++) dispatch_rand(alu_op_t'(i));
        end
        finish_test("branches and JAL");

        for (int r = 0; r < REPS; r++) begin
            for (int i = int'(MUL); i <= int'(REMU); i++) dispatch_rand(alu_op_t'(i));
        end
        for (int i = int'(DIV); i <= int'(REMU); i++) begin
            dispatch(alu_op_t'(i), rand_bits(32), '0, '0, '0);
        end
        dispatch(DIV, 32'h8000_0000, '1, '0, '0);
        dispatch(REM, 32'h8000_0000, '1, '0, '0);
        finish_test("muldiv ops");

        repeat (MIX_OPS) dispatch_rand(alu_op_t'(rand_bits(5) % 24));
        finish_test("interleaved ops");

        @(posedge clk);
        stall_en = 1'b1;
        @(negedge clk);
        repeat (MIX_OPS) dispatch_rand(alu_op_t'(rand_bits(5) % 24));
        finish_test("commit back-pressure");
        @(posedge clk);
        stall_en = 1'b0;
        @(negedge clk);

        check_lat = 1'b1;
        repeat (8) dispatch_rand(alu_op_t'(rand_bits(4) % 10));
        finish_test("integer latency");
        check_lat = 1'b0;

        $display("Done: %0d commits, %0d branch pulses, %0d errors",
                 n_commits, n_branches, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
